// File: hdl/rpc_phy_cfg.svh
`ifndef RPC_PHY_CFG_SVH
`define RPC_PHY_CFG_SVH

// One DRAM word and the slices it is cut into on the DB bus
`define RPC_WORD_W 256
`define RPC_SLICE_W 32
`define RPC_HALF_W 16
`define RPC_SLICES 8

// Both write masks side by side
`define RPC_MASK_W 64

// Command fields
// The burst is the field value plus one word
`define RPC_OP_LSB 28
`define RPC_OP_W 4
`define RPC_BL_LSB 24
`define RPC_BL_W 3

// Idle cycles between command and read window
`define RPC_RD_LATENCY 4

`endif

// File: hdl/rpc_phy_pkg.sv
`include "rpc_phy_cfg.svh"

package rpc_phy_pkg;

  // Width-named payload types
  typedef logic [`RPC_WORD_W-1:0] word_t;
  typedef logic [`RPC_SLICE_W-1:0] slice_t;
  typedef logic [`RPC_MASK_W-1:0] mask_t;
  typedef logic [$clog2(`RPC_SLICES)-1:0] slice_idx_t;

  // Opcode field of the command
  // Unknown codes act as NOP
  typedef enum logic [`RPC_OP_W-1:0] {
    OP_NOP = 4'h0,
    OP_WR  = 4'h1,
    OP_RD  = 4'h2
  } op_e;

  // Sequencer phases
  typedef enum logic [2:0] {
    IDLE,
    CMD,
    WR_MASK,
    WR_DATA,
    RD_WAIT,
    RD_DATA
  } phase_e;

  // Source of the shared DB bus
  typedef enum logic [1:0] {
    PL_CMD,
    PL_MASK,
    PL_DATA
  } payload_e;

endpackage

// File: hdl/rpc_seq_fsm.sv
`timescale 1ns/100ps

module rpc_seq_fsm (
  input  logic                  clk_0_i,
  input  logic                  rst_ni,
  input  logic                  cmd_valid_i,
  input  rpc_phy_pkg::op_e      op_i,
  input  logic                  dqs_i,
  input  logic                  mask_done_i,
  input  logic                  wait_done_i,
  input  logic                  word_done_i,
  input  logic                  last_word_i,
  output logic                  cmd_ready_o,
  output logic                  accept_o,
  output rpc_phy_pkg::phase_e   phase_o,
  output rpc_phy_pkg::payload_e payload_o,
  output logic                  slice_step_o,
  output logic                  data_ready_o,
  output logic                  cs_no_o,
  output logic                  stb_o,
  output logic                  db_oe_o,
  output logic                  db_ie_o
);

  rpc_phy_pkg::phase_e state_d, state_q;
  rpc_phy_pkg::op_e op_d, op_q;

  // Only an idle sequencer takes a command
  assign cmd_ready_o = (state_q == rpc_phy_pkg::IDLE);
  assign accept_o    = cmd_valid_i & cmd_ready_o;

  // Opcode is decoded once, when the command is taken
  always_comb begin
    case (op_i)
      rpc_phy_pkg::OP_WR: op_d = rpc_phy_pkg::OP_WR;
      rpc_phy_pkg::OP_RD: op_d = rpc_phy_pkg::OP_RD;
      default:            op_d = rpc_phy_pkg::OP_NOP;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Phase sequencing
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      rpc_phy_pkg::IDLE: begin
        if (accept_o) begin
          state_d = rpc_phy_pkg::CMD;
        end
      end
      rpc_phy_pkg::CMD: begin
        // NOP ends right after its command cycle
        case (op_q)
          rpc_phy_pkg::OP_WR: state_d = rpc_phy_pkg::WR_MASK;
          rpc_phy_pkg::OP_RD: state_d = rpc_phy_pkg::RD_WAIT;
          default:            state_d = rpc_phy_pkg::IDLE;
        endcase
      end
      rpc_phy_pkg::WR_MASK: begin
        if (mask_done_i) begin
          state_d = rpc_phy_pkg::WR_DATA;
        end
      end
      rpc_phy_pkg::RD_WAIT: begin
        if (wait_done_i) begin
          state_d = rpc_phy_pkg::RD_DATA;
        end
      end
      rpc_phy_pkg::WR_DATA, rpc_phy_pkg::RD_DATA: begin
        // Leave on the eighth slice of the final word
        if (word_done_i && last_word_i) begin
          state_d = rpc_phy_pkg::IDLE;
        end
      end
      default: state_d = rpc_phy_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_0_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= rpc_phy_pkg::IDLE;
      op_q    <= rpc_phy_pkg::OP_NOP;
      cs_no_o <= 1'b1;
      stb_o   <= 1'b0;
      db_oe_o <= 1'b0;
      db_ie_o <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept_o) begin
        op_q <= op_d;
      end
      // Strobes follow the next phase so they line up with it
      cs_no_o <= (state_d == rpc_phy_pkg::IDLE);
      stb_o   <= (state_d == rpc_phy_pkg::CMD);
      db_oe_o <= (state_d == rpc_phy_pkg::CMD) || (state_d == rpc_phy_pkg::WR_MASK) ||
                 (state_d == rpc_phy_pkg::WR_DATA);
      db_ie_o <= (state_d == rpc_phy_pkg::RD_DATA);
    end
  end

  assign phase_o = state_q;

  // DB source per phase
  // The command register shows while idle
  always_comb begin
    case (state_q)
      rpc_phy_pkg::WR_MASK: payload_o = rpc_phy_pkg::PL_MASK;
      rpc_phy_pkg::WR_DATA: payload_o = rpc_phy_pkg::PL_DATA;
      default:              payload_o = rpc_phy_pkg::PL_CMD;
    endcase
  end

  // Writes step every cycle and reads only on a strobe
  assign slice_step_o = (state_q == rpc_phy_pkg::WR_DATA) ||
                        ((state_q == rpc_phy_pkg::RD_DATA) && dqs_i);

  // Ask for the next word one cycle before it is needed
  assign data_ready_o = ((state_q == rpc_phy_pkg::WR_MASK) && mask_done_i) ||
                        ((state_q == rpc_phy_pkg::WR_DATA) && word_done_i && !last_word_i);

endmodule

// File: hdl/rpc_burst_timer.sv
`timescale 1ns/100ps
`include "rpc_phy_cfg.svh"

module rpc_burst_timer (
  input  logic                    clk_0_i,
  input  logic                    rst_ni,
  input  logic                    accept_i,
  input  logic [`RPC_BL_W-1:0]    burst_i,
  input  rpc_phy_pkg::phase_e     phase_i,
  input  logic                    slice_step_i,
  output rpc_phy_pkg::slice_idx_t slice_idx_o,
  output logic                    mask_done_o,
  output logic                    wait_done_o,
  output logic                    word_done_o,
  output logic                    last_word_o
);

  localparam int wait_w = $clog2(`RPC_RD_LATENCY + 1);

  logic                    mask_cnt_q;
  logic [wait_w-1:0]       wait_cnt_q;
  rpc_phy_pkg::slice_idx_t slice_idx_q;
  // Words still to go after the current one
  logic [`RPC_BL_W-1:0]    words_left_q;

  always_ff @(posedge clk_0_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mask_cnt_q   <= 1'b0;
      wait_cnt_q   <= '0;
      slice_idx_q  <= '0;
      words_left_q <= '0;
    end else if (accept_i) begin
      mask_cnt_q   <= 1'b0;
      wait_cnt_q   <= '0;
      slice_idx_q  <= '0;
      words_left_q <= burst_i;
    end else begin
      if (phase_i == rpc_phy_pkg::WR_MASK) begin
        mask_cnt_q <= ~mask_cnt_q;
      end
      if (phase_i == rpc_phy_pkg::RD_WAIT) begin
        wait_cnt_q <= wait_cnt_q + 1'b1;
      end
      if (slice_step_i) begin
        // Wraps to lane 0 after the eighth slice
        slice_idx_q <= slice_idx_q + 1'b1;
      end
      if (word_done_o && !last_word_o) begin
        words_left_q <= words_left_q - 1'b1;
      end
    end
  end

  assign slice_idx_o = slice_idx_q;
  assign mask_done_o = (phase_i == rpc_phy_pkg::WR_MASK) && mask_cnt_q;
  assign wait_done_o = (phase_i == rpc_phy_pkg::RD_WAIT) &&
                       (wait_cnt_q == wait_w'(`RPC_RD_LATENCY - 1));
  assign word_done_o = slice_step_i &&
                       (slice_idx_q == rpc_phy_pkg::slice_idx_t'(`RPC_SLICES - 1));
  assign last_word_o = (words_left_q == '0);

endmodule

// File: hdl/rpc_tx_mux.sv
`timescale 1ns/100ps
`include "rpc_phy_cfg.svh"

module rpc_tx_mux (
  input  logic                    clk_0_i,
  input  logic                    rst_ni,
  input  logic                    accept_i,
  input  logic                    data_take_i,
  input  rpc_phy_pkg::slice_t     cmd_i,
  input  rpc_phy_pkg::mask_t      mask_i,
  input  rpc_phy_pkg::word_t      data_i,
  input  rpc_phy_pkg::payload_e   payload_i,
  input  rpc_phy_pkg::phase_e     phase_i,
  input  rpc_phy_pkg::slice_idx_t slice_idx_i,
  output rpc_phy_pkg::slice_t     db_o
);

  rpc_phy_pkg::slice_t cmd_q;
  rpc_phy_pkg::mask_t  mask_q;
  // Pipeline stage between the word source and the DB bus
  rpc_phy_pkg::word_t  data_q;
  logic                mask_sel_q;
  rpc_phy_pkg::slice_t mask_slice;
  rpc_phy_pkg::slice_t data_slice;

  // First DDR half goes in the upper bits of the slice
  function automatic rpc_phy_pkg::slice_t half_swap(input rpc_phy_pkg::slice_t s);
    half_swap = {s[`RPC_HALF_W-1:0], s[`RPC_SLICE_W-1:`RPC_HALF_W]};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Payload registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_0_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_q      <= '0;
      mask_sel_q <= 1'b0;
    end else if (accept_i) begin
      cmd_q      <= cmd_i;
      mask_sel_q <= 1'b0;
    end else if (phase_i == rpc_phy_pkg::WR_MASK) begin
      // Second mask pair on the next cycle
      mask_sel_q <= ~mask_sel_q;
    end
  end

  always_ff @(posedge clk_0_i) begin
    if (accept_i) begin
      mask_q <= mask_i;
    end
    if (data_take_i) begin
      data_q <= data_i;
    end
  end

  // Mask pair 0 covers bits 31:0, pair 1 bits 63:32
  assign mask_slice = half_swap(mask_q[mask_sel_q*`RPC_SLICE_W +: `RPC_SLICE_W]);
  assign data_slice = half_swap(data_q[slice_idx_i*`RPC_SLICE_W +: `RPC_SLICE_W]);

  always_comb begin
    case (payload_i)
      rpc_phy_pkg::PL_MASK: db_o = mask_slice;
      rpc_phy_pkg::PL_DATA: db_o = data_slice;
      default:              db_o = cmd_q;
    endcase
  end

endmodule

// File: hdl/rpc_rx_assembler.sv
`timescale 1ns/100ps
`include "rpc_phy_cfg.svh"

module rpc_rx_assembler (
  input  logic                    clk_0_i,
  input  logic                    rst_ni,
  input  logic                    capture_i,
  input  rpc_phy_pkg::slice_idx_t slice_idx_i,
  input  logic                    word_done_i,
  input  logic                    last_word_i,
  input  rpc_phy_pkg::slice_t     db_i,
  output rpc_phy_pkg::word_t      data_o,
  output logic                    data_valid_o,
  output logic                    data_last_o
);

  rpc_phy_pkg::word_t data_q;
  logic               valid_q;
  logic               last_q;
  logic               word_end;

  // Eighth slice of a word arrives in this cycle
  assign word_end = capture_i & word_done_i;

  ////////////////////////////////////////////////////////////////////////////
  // Slice packing
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_0_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_q <= '0;
    end else if (capture_i) begin
      // Slices land raw so lane s holds bits 32s+31 down to 32s
      data_q[slice_idx_i*`RPC_SLICE_W +: `RPC_SLICE_W] <= db_i;
    end
  end

  // Valid and last come out with the full word
  always_ff @(posedge clk_0_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      valid_q <= word_end;
      last_q  <= word_end & last_word_i;
    end
  end

  assign data_o       = data_q;
  assign data_valid_o = valid_q;
  assign data_last_o  = last_q;

endmodule

// File: hdl/rpc_phy.sv
`timescale 1ns/100ps
`include "rpc_phy_cfg.svh"

module rpc_phy (
  input  logic                clk_0_i,
  input  logic                rst_ni,
  input  rpc_phy_pkg::slice_t cmd_i,
  input  logic                cmd_valid_i,
  output logic                cmd_ready_o,
  input  rpc_phy_pkg::word_t  data_i,
  input  rpc_phy_pkg::mask_t  mask_i,
  output logic                data_ready_o,
  output rpc_phy_pkg::word_t  data_o,
  output logic                data_valid_o,
  output logic                data_last_o,
  output logic                cs_no_o,
  output logic                stb_o,
  output logic                db_oe_o,
  output logic                db_ie_o,
  output rpc_phy_pkg::slice_t db_o,
  input  logic                dqs_i,
  input  rpc_phy_pkg::slice_t db_i
);

  rpc_phy_pkg::op_e        op;
  logic [`RPC_BL_W-1:0]    burst;
  logic                    accept;
  rpc_phy_pkg::phase_e     phase;
  rpc_phy_pkg::payload_e   payload;
  logic                    slice_step;
  logic                    capture;
  rpc_phy_pkg::slice_idx_t slice_idx;
  logic                    mask_done;
  logic                    wait_done;
  logic                    word_done;
  logic                    last_word;

  // Command fields
  assign op    = rpc_phy_pkg::op_e'(cmd_i[`RPC_OP_LSB +: `RPC_OP_W]);
  assign burst = cmd_i[`RPC_BL_LSB +: `RPC_BL_W];

  // Slice steps only reach the assembler during a read
  assign capture = slice_step & (phase == rpc_phy_pkg::RD_DATA);

  rpc_seq_fsm i_seq_fsm (
    .clk_0_i      (clk_0_i),
    .rst_ni       (rst_ni),
    .cmd_valid_i  (cmd_valid_i),
    .op_i         (op),
    .dqs_i        (dqs_i),
    .mask_done_i  (mask_done),
    .wait_done_i  (wait_done),
    .word_done_i  (word_done),
    .last_word_i  (last_word),
    .cmd_ready_o  (cmd_ready_o),
    .accept_o     (accept),
    .phase_o      (phase),
    .payload_o    (payload),
    .slice_step_o (slice_step),
    .data_ready_o (data_ready_o),
    .cs_no_o      (cs_no_o),
    .stb_o        (stb_o),
    .db_oe_o      (db_oe_o),
    .db_ie_o      (db_ie_o)
  );

  rpc_burst_timer i_burst_timer (
    .clk_0_i      (clk_0_i),
    .rst_ni       (rst_ni),
    .accept_i     (accept),
    .burst_i      (burst),
    .phase_i      (phase),
    .slice_step_i (slice_step),
    .slice_idx_o  (slice_idx),
    .mask_done_o  (mask_done),
    .wait_done_o  (wait_done),
    .word_done_o  (word_done),
    .last_word_o  (last_word)
  );

  rpc_tx_mux i_tx_mux (
    .clk_0_i     (clk_0_i),
    .rst_ni      (rst_ni),
    .accept_i    (accept),
    .data_take_i (data_ready_o),
    .cmd_i       (cmd_i),
    .mask_i      (mask_i),
    .data_i      (data_i),
    .payload_i   (payload),
    .phase_i     (phase),
    .slice_idx_i (slice_idx),
    .db_o        (db_o)
  );

  rpc_rx_assembler i_rx_assembler (
    .clk_0_i      (clk_0_i),
    .rst_ni       (rst_ni),
    .capture_i    (capture),
    .slice_idx_i  (slice_idx),
    .word_done_i  (word_done),
    .last_word_i  (last_word),
    .db_i         (db_i),
    .data_o       (data_o),
    .data_valid_o (data_valid_o),
    .data_last_o  (data_last_o)
  );

endmodule

// File: verif/rpc_phy_tb.sv
`timescale 1ns/100ps
`include "rpc_phy_cfg.svh"

module rpc_phy_tb;

  localparam int clk_period = 100;
  localparam int drive_dly = 10;
  localparam string stim_file = "verif/rpc_phy_stim.txt";

  logic clk_0_i;
  logic rst_ni;
  rpc_phy_pkg::slice_t cmd_i;
  logic cmd_valid_i;
  logic cmd_ready_o;
  rpc_phy_pkg::word_t data_i;
  rpc_phy_pkg::mask_t mask_i;
  logic data_ready_o;
  rpc_phy_pkg::word_t data_o;
  logic data_valid_o;
  logic data_last_o;
  logic cs_no_o;
  logic stb_o;
  logic db_oe_o;
  logic db_ie_o;
  rpc_phy_pkg::slice_t db_o;
  logic dqs_i;
  rpc_phy_pkg::slice_t db_i;

  // Transactions from the stim file
  rpc_phy_pkg::slice_t cmd_list[$];
  rpc_phy_pkg::mask_t mask_list[$];
  rpc_phy_pkg::slice_t dbm0_list[$];
  rpc_phy_pkg::slice_t dbm1_list[$];
  rpc_phy_pkg::word_t src_list[$];
  rpc_phy_pkg::word_t exp_list[$];
  bit stim_loaded = 1'b0;
  int n_words = 0;

  // Read word expected on the outputs in the next cycle
  logic pend_valid;
  logic pend_last;
  rpc_phy_pkg::word_t pend_word;

  rpc_phy i_dut (
    .clk_0_i      (clk_0_i),
    .rst_ni       (rst_ni),
    .cmd_i        (cmd_i),
    .cmd_valid_i  (cmd_valid_i),
    .cmd_ready_o  (cmd_ready_o),
    .data_i       (data_i),
    .mask_i       (mask_i),
    .data_ready_o (data_ready_o),
    .data_o       (data_o),
    .data_valid_o (data_valid_o),
    .data_last_o  (data_last_o),
    .cs_no_o      (cs_no_o),
    .stb_o        (stb_o),
    .db_oe_o      (db_oe_o),
    .db_ie_o      (db_ie_o),
    .db_o         (db_o),
    .dqs_i        (dqs_i),
    .db_i         (db_i)
  );

  always #(clk_period / 2) clk_0_i = ~clk_0_i;

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_slice(input rpc_phy_pkg::slice_t got, input rpc_phy_pkg::slice_t exp,
                             input string what);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_word(input rpc_phy_pkg::word_t got, input rpc_phy_pkg::word_t exp,
                            input string what);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  // Control strobes and the ready level of one cycle
  task automatic expect_strobes(input logic cs_n, input logic stb, input logic oe,
                                input logic ie, input logic ready);
    check_bit(cs_no_o, cs_n, "cs_no_o");
    check_bit(stb_o, stb, "stb_o");
    check_bit(db_oe_o, oe, "db_oe_o");
    check_bit(db_ie_o, ie, "db_ie_o");
    check_bit(cmd_ready_o, ready, "cmd_ready_o");
  endtask

  task automatic verify_read_out();
    check_bit(data_valid_o, pend_valid, "data_valid_o");
    check_bit(data_last_o, pend_valid & pend_last, "data_last_o");
    if (pend_valid) begin
      check_word(data_o, pend_word, "read word on data_o");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Timing and stim file
  ////////////////////////////////////////////////////////////////////////////

  // Inputs change shortly after the rising edge
  task automatic next_cycle();
    @(posedge clk_0_i);
    #drive_dly;
  endtask

  // Outputs are settled at the falling edge
  task automatic sample_point();
    @(negedge clk_0_i);
  endtask

  // Words in a burst are the field plus one and a NOP carries none
  function automatic int words_of(input rpc_phy_pkg::slice_t cmd);
    logic [`RPC_OP_W-1:0] op;
    op = cmd[`RPC_OP_LSB +: `RPC_OP_W];
    if (op == rpc_phy_pkg::OP_WR || op == rpc_phy_pkg::OP_RD) begin
      return int'(cmd[`RPC_BL_LSB +: `RPC_BL_W]) + 1;
    end
    return 0;
  endfunction

  // Next line that is neither blank nor a comment
  task automatic read_line(input int fd, output string line, output bit found);
    int n_chars;
    found = 1'b0;
    line = "";
    n_chars = $fgets(line, fd);
    while (n_chars > 0 && !found) begin
      if (line.len() > 1 && line[0] != "#") begin
        found = 1'b1;
      end else begin
        n_chars = $fgets(line, fd);
      end
    end
  endtask

  task automatic load_stim();
    int fd;
    string line;
    bit found;
    rpc_phy_pkg::slice_t cmd;
    rpc_phy_pkg::mask_t mask;
    rpc_phy_pkg::slice_t m0;
    rpc_phy_pkg::slice_t m1;
    rpc_phy_pkg::word_t w;
    fd = $fopen(stim_file, "r");
    if (fd == 0) begin
      fail_run("Could not open the stimulus file");
    end
    read_line(fd, line, found);
    while (found) begin
      if ($sscanf(line, "%h %h %h %h", cmd, mask, m0, m1) != 4) begin
        fail_run("A header line in the stimulus file is malformed");
      end
      cmd_list.push_back(cmd);
      mask_list.push_back(mask);
      dbm0_list.push_back(m0);
      dbm1_list.push_back(m1);
      // Source line then expected line for each word
      for (int i = 0; i < 2 * words_of(cmd); i++) begin
        read_line(fd, line, found);
        if (!found || $sscanf(line, "%h", w) != 1) begin
          fail_run("The stimulus file ends inside a transaction");
        end
        if (i % 2 == 0) begin
          src_list.push_back(w);
        end else begin
          exp_list.push_back(w);
        end
      end
      read_line(fd, line, found);
    end
    $fclose(fd);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Transactions
  ////////////////////////////////////////////////////////////////////////////

  // Accept edge and then the command cycle
  task automatic send_cmd(input rpc_phy_pkg::slice_t cmd, input rpc_phy_pkg::mask_t mask,
                          input rpc_phy_pkg::word_t first_word);
    next_cycle();
    cmd_i = cmd;
    mask_i = mask;
    data_i = first_word;
    cmd_valid_i = 1'b1;
    sample_point();
    expect_strobes(1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
    check_bit(data_valid_o, 1'b0, "data_valid_o");
    next_cycle();
    cmd_valid_i = 1'b0;
    sample_point();
    expect_strobes(1'b0, 1'b1, 1'b1, 1'b0, 1'b0);
    check_slice(db_o, cmd, "command on db_o");
  endtask

  task automatic run_write(input int n, input int base, input rpc_phy_pkg::slice_t m0,
                           input rpc_phy_pkg::slice_t m1);
    logic pulse_due;
    next_cycle();
    sample_point();
    expect_strobes(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
    check_slice(db_o, m0, "first mask slice");
    check_bit(data_ready_o, 1'b0, "data_ready_o");
    next_cycle();
    sample_point();
    expect_strobes(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
    check_slice(db_o, m1, "second mask slice");
    if (data_ready_o !== 1'b1) begin
      fail_run("The data_ready_o pulse is missing in the second mask cycle");
    end
    for (int w = 0; w < n; w++) begin
      for (int s = 0; s < `RPC_SLICES; s++) begin
        next_cycle();
        // Next word goes out once the last one was taken
        if (s == 0 && w + 1 < n) begin
          data_i = src_list[base + w + 1];
        end
        sample_point();
        expect_strobes(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
        check_slice(db_o, exp_list[base + w][s * `RPC_SLICE_W +: `RPC_SLICE_W],
                    $sformatf("slice %0d of write word %0d", s, w));
        pulse_due = (s == `RPC_SLICES - 1) && (w < n - 1);
        if (pulse_due && data_ready_o !== 1'b1) begin
          fail_run($sformatf("The data_ready_o pulse is missing after write word %0d", w));
        end else if (!pulse_due) begin
          check_bit(data_ready_o, 1'b0, "data_ready_o");
        end
      end
    end
    // Frame of 3 + 8N cycles is over
    next_cycle();
    sample_point();
    expect_strobes(1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
    check_bit(data_ready_o, 1'b0, "data_ready_o");
  endtask

  // DRAM model drives one read cycle with or without a slice
  task automatic dram_cycle(input logic strobe, input rpc_phy_pkg::slice_t slice,
                            input logic word_end, input rpc_phy_pkg::word_t exp_word,
                            input logic exp_last);
    next_cycle();
    dqs_i = strobe;
    db_i = slice;
    sample_point();
    expect_strobes(1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
    verify_read_out();
    pend_valid = word_end;
    pend_word = exp_word;
    pend_last = exp_last;
  endtask

  task automatic run_read(input int n, input int base);
    int gap;
    for (int i = 0; i < `RPC_RD_LATENCY; i++) begin
      next_cycle();
      sample_point();
      expect_strobes(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
      check_bit(data_valid_o, 1'b0, "data_valid_o");
    end
    pend_valid = 1'b0;
    for (int w = 0; w < n; w++) begin
      for (int s = 0; s < `RPC_SLICES; s++) begin
        // Zero to three idle strobe cycles with junk on the bus
        gap = int'($urandom % 4);
        repeat (gap) dram_cycle(1'b0, $urandom, 1'b0, '0, 1'b0);
        dram_cycle(1'b1, src_list[base + w][s * `RPC_SLICE_W +: `RPC_SLICE_W],
                   s == `RPC_SLICES - 1, exp_list[base + w], w == n - 1);
      end
    end
    // Final word and last flag come with the return to idle
    next_cycle();
    dqs_i = 1'b0;
    db_i = '0;
    sample_point();
    expect_strobes(1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
    verify_read_out();
    pend_valid = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int base;
    int n;
    logic [`RPC_OP_W-1:0] op;
    void'($urandom(32'h773a));
    clk_0_i = 1'b0;
    rst_ni = 1'b0;
    cmd_i = '0;
    cmd_valid_i = 1'b0;
    data_i = '0;
    mask_i = '0;
    dqs_i = 1'b0;
    db_i = '0;
    pend_valid = 1'b0;
    pend_last = 1'b0;
    pend_word = '0;
    load_stim();
    n_words = src_list.size();
    stim_loaded = 1'b1;
    repeat (16) @(posedge clk_0_i);
    #drive_dly;
    rst_ni = 1'b1;
    // Everything inactive out of reset
    sample_point();
    expect_strobes(1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
    check_bit(data_ready_o, 1'b0, "data_ready_o");
    check_bit(data_valid_o, 1'b0, "data_valid_o");
    check_bit(data_last_o, 1'b0, "data_last_o");
    check_slice(db_o, '0, "db_o after reset");
    check_word(data_o, '0, "data_o after reset");
    base = 0;
    for (int r = 0; r < cmd_list.size(); r++) begin
      op = cmd_list[r][`RPC_OP_LSB +: `RPC_OP_W];
      n = words_of(cmd_list[r]);
      send_cmd(cmd_list[r], mask_list[r], (n > 0) ? src_list[base] : '0);
      if (op == rpc_phy_pkg::OP_WR) begin
        run_write(n, base, dbm0_list[r], dbm1_list[r]);
      end else if (op == rpc_phy_pkg::OP_RD) begin
        run_read(n, base);
      end else begin
        // NOP goes straight back to idle
        next_cycle();
        sample_point();
        expect_strobes(1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
      end
      base += n;
    end
    next_cycle();
    sample_point();
    expect_strobes(1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
    $display("SIMULATION PASSED");
    $finish;
  end

  // Budget grows with the number of stim words
  initial begin
    wait (stim_loaded);
    repeat (40 * n_words + 200) @(posedge clk_0_i);
    fail_run("Timeout because the run did not finish within its cycle budget");
  end

endmodule

// File: all.f
+incdir+hdl
hdl/rpc_phy_pkg.sv
hdl/rpc_seq_fsm.sv
hdl/rpc_burst_timer.sv
hdl/rpc_tx_mux.sv
hdl/rpc_rx_assembler.sv
hdl/rpc_phy.sv
verif/rpc_phy_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing -f all.f --top-module rpc_phy_tb --Mdir "$build_dir" -o rpc_phy_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$build_dir/rpc_phy_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if grep -q "SIMULATION FAILED" "$log_file"; then
  echo "Testbench reported a failure"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulator exited with status $sim_status"
  exit 1
fi
if ! grep -q "SIMULATION PASSED" "$log_file"; then
  echo "Simulation ended without a result"
  exit 1
fi
exit 0

// File: verif/rpc_phy_stim.txt
# Header columns are cmd, mask and the two expected DB mask slices, all in hex
# Each word adds a line with the source word and a line with the expected word or DB slices
050000a5 0000000000000000 00000000 00000000
12000c3f 0123456789abcdef cdef89ab 45670123
a7a75757a6a65656a5a55555a4a45454a3a35353a2a25252a1a15151a0a05050
5757a7a75656a6a65555a5a55454a4a45353a3a35252a2a25151a1a15050a0a0
1727374716263646152535451424344413233343122232421121314110203040
3747172736461626354515253444142433431323324212223141112130401020
deadbe77deadbe66deadbe55deadbe44deadbe33deadbe22deadbe11deadbe00
be77deadbe66deadbe55deadbe44deadbe33deadbe22deadbe11deadbe00dead
21000040 0000000000000000 00000000 00000000
0123456789abcdeffedcba98765432100f1e2d3c4b5a69788796a5b4c3d2e1f0
0123456789abcdeffedcba98765432100f1e2d3c4b5a69788796a5b4c3d2e1f0
c001d00dcafef00d5a5aa5a53c3cc3c30000ffff1234abcd13579bdf2468ace0
c001d00dcafef00d5a5aa5a53c3cc3c30000ffff1234abcd13579bdf2468ace0
